// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = execUnitTb
LINT_TOP   = execUnit
FILELIST   = execUnit.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: execUnit.f
hdl/instrPkg.sv
hdl/resultPkg.sv
hdl/issueDecode.sv
hdl/addPipe.sv
hdl/mulPipe.sv
hdl/commitBuffer.sv
hdl/execUnit.sv
tests/clockGen.sv
tests/execUnitTb.sv

// File: hdl/addPipe.sv
`timescale 1ns/10ps
`default_nettype none

module addPipe #(
	parameter int ADD_DEPTH = 2
) (
	input wire logic clock,
	input wire logic reset,
	input wire instrPkg::command_t cmd,
	input wire resultPkg::issueNo_t tag,
	output resultPkg::wbResult_t result
);
	import instrPkg::*;
	import resultPkg::*;

	wbResult_t sum;	// Output of the arithmetic stage

	always_comb begin
		sum.token.valid = cmd.valid;
		sum.token.issueNo = tag;
		sum.token.dst = cmd.dst;
		sum.data = (cmd.op == opSub) ? cmd.src1 - cmd.src2 : cmd.src1 + cmd.src2;
	end

	//////////////////////////////////////////////////////////////////////
	// Delay stages after the adder
	//////////////////////////////////////////////////////////////////////

	generate
		if (ADD_DEPTH == 1) begin : gNoStage
			assign result = sum;	// Issue register is the only stage
		end else begin : gStages
			wbResult_t stage [ADD_DEPTH-1];

			always_ff @(posedge clock) begin
				stage[0] <= sum;
				for (int i = 1; i < ADD_DEPTH - 1; i++) begin
					stage[i] <= stage[i-1];
				end
				if (reset) begin
					for (int i = 0; i < ADD_DEPTH - 1; i++) begin
						stage[i].token.valid <= 1'b0;
					end
				end
			end

			assign result = stage[ADD_DEPTH-2];
		end
	endgenerate

endmodule

`default_nettype wire

// File: hdl/commitBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module commitBuffer (
	input wire logic clock,
	input wire logic reset,
	input wire logic issued,
	input wire resultPkg::wbResult_t addResult,
	input wire resultPkg::wbResult_t mulResult,
	input wire logic commitGrant,
	output resultPkg::wbResult_t writeBack,
	output logic full
);
	import instrPkg::*;
	import resultPkg::*;

	localparam int SLOTS = 2 ** $bits(issueNo_t);

	data_t slotData [SLOTS];
	regIdx_t slotDst [SLOTS];
	logic [SLOTS-1:0] filled;	// Result present in slot
	issueNo_t head;	// Oldest issued command
	logic [4:0] count;	// Allocated slots
	logic commit;

	assign commit = filled[head] & commitGrant;
	assign full = (count == 5'(SLOTS));

	//////////////////////////////////////////////////////////////////////
	// Slot write from both pipelines
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (addResult.token.valid) begin
			slotData[addResult.token.issueNo] <= addResult.data;
			slotDst[addResult.token.issueNo] <= addResult.token.dst;
		end
		if (mulResult.token.valid) begin
			slotData[mulResult.token.issueNo] <= mulResult.data;
			slotDst[mulResult.token.issueNo] <= mulResult.token.dst;
		end
	end

	// Commit always clears a different slot than the ones being filled
	always_ff @(posedge clock) begin
		if (reset) begin
			filled <= '0;
		end else begin
			if (commit) begin
				filled[head] <= 1'b0;
			end
			if (addResult.token.valid) begin
				filled[addResult.token.issueNo] <= 1'b1;
			end
			if (mulResult.token.valid) begin
				filled[mulResult.token.issueNo] <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Head pointer, occupancy and in-order write-back
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			count <= '0;
		end else begin
			if (commit) begin
				head <= head + 1'b1;
			end
			case ({issued, commit})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		writeBack.token.issueNo <= head;
		writeBack.token.dst <= slotDst[head];
		writeBack.data <= slotData[head];
		if (reset) begin
			writeBack.token.valid <= 1'b0;
		end else begin
			writeBack.token.valid <= commit;	// One pulse per commit
		end
	end

	// A slot reserved at issue is filled once before its commit
	assert property (@(posedge clock) disable iff (reset)
		addResult.token.valid |-> !filled[addResult.token.issueNo])
		else $error("commitBuffer: add result into a filled slot");

	assert property (@(posedge clock) disable iff (reset)
		mulResult.token.valid |-> !filled[mulResult.token.issueNo])
		else $error("commitBuffer: multiply result into a filled slot");

	assert property (@(posedge clock) disable iff (reset)
		count <= 5'(SLOTS))
		else $error("commitBuffer: occupancy above slot count");

	assert property (@(posedge clock) disable iff (reset)
		(addResult.token.valid && mulResult.token.valid)
			|-> (addResult.token.issueNo != mulResult.token.issueNo))
		else $error("commitBuffer: both pipelines carry the same issue number");

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit #(
	parameter int ADD_DEPTH = 2,
	parameter int MUL_DEPTH = 4
) (
	input wire logic clock,
	input wire logic reset,
	input wire instrPkg::command_t command,
	input wire logic commitGrant,
	output resultPkg::wbResult_t writeBack,
	output logic full
);
	import instrPkg::*;
	import resultPkg::*;

	command_t addCmd;
	command_t mulCmd;
	issueNo_t addTag;
	issueNo_t mulTag;
	logic issued;	// Slot reserved
	wbResult_t addResult;
	wbResult_t mulResult;

	//////////////////////////////////////////////////////////////////////
	// Decode and issue
	//////////////////////////////////////////////////////////////////////

	issueDecode i_issueDecode (
		.clock		(clock),
		.reset		(reset),
		.command	(command),
		.full		(full),
		.addCmd		(addCmd),
		.mulCmd		(mulCmd),
		.addTag		(addTag),
		.mulTag		(mulTag),
		.issued		(issued)
	);

	addPipe #(
		.ADD_DEPTH	(ADD_DEPTH)
	) i_addPipe (
		.clock		(clock),
		.reset		(reset),
		.cmd		(addCmd),
		.tag		(addTag),
		.result		(addResult)
	);

	mulPipe #(
		.MUL_DEPTH	(MUL_DEPTH)
	) i_mulPipe (
		.clock		(clock),
		.reset		(reset),
		.cmd		(mulCmd),
		.tag		(mulTag),
		.result		(mulResult)
	);

	//////////////////////////////////////////////////////////////////////
	// Reorder and commit
	//////////////////////////////////////////////////////////////////////

	commitBuffer i_commitBuffer (
		.clock		(clock),
		.reset		(reset),
		.issued		(issued),
		.addResult	(addResult),
		.mulResult	(mulResult),
		.commitGrant	(commitGrant),
		.writeBack	(writeBack),
		.full		(full)
	);

endmodule

`default_nettype wire

// File: hdl/instrPkg.sv
`default_nettype none

package instrPkg;

	//////////////////////////////////////////////////////////////////////
	// Command side of the execution unit
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		opAdd = 2'b00,	// src1 + src2
		opSub = 2'b01,	// src1 - src2
		opMul = 2'b10,	// Low half of src1 * src2
		opMov = 2'b11	// Folded into the adder as src1 + 0
	} opCode_t;

	typedef logic [31:0] data_t;	// Operand or result word
	typedef logic [4:0] regIdx_t;	// Destination register

	typedef struct packed {
		logic valid;
		opCode_t op;
		regIdx_t dst;
		data_t src1;
		data_t src2;
	} command_t;	// 72 bits

endpackage

`default_nettype wire

// File: hdl/issueDecode.sv
`timescale 1ns/10ps
`default_nettype none

module issueDecode (
	input wire logic clock,
	input wire logic reset,
	input wire instrPkg::command_t command,
	input wire logic full,
	output instrPkg::command_t addCmd,
	output instrPkg::command_t mulCmd,
	output resultPkg::issueNo_t addTag,
	output resultPkg::issueNo_t mulTag,
	output logic issued
);
	import instrPkg::*;
	import resultPkg::*;

	issueNo_t issueCnt;	// Next issue number, wraps at 16
	logic accept;
	logic toMul;

	assign accept = command.valid & ~full;
	assign toMul = (command.op == opMul);
	assign issued = accept;	// Reserves a slot this cycle

	//////////////////////////////////////////////////////////////////////
	// Issue register, first stage of both pipelines
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		addCmd <= command;
		addCmd.valid <= accept & ~toMul;
		if (command.op == opMov) begin	// Move becomes add with zero
			addCmd.op <= opAdd;
			addCmd.src2 <= '0;
		end
		mulCmd <= command;
		mulCmd.valid <= accept & toMul;
		addTag <= issueCnt;
		mulTag <= issueCnt;
		if (reset) begin
			addCmd.valid <= 1'b0;
			mulCmd.valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			issueCnt <= '0;
		end else if (accept) begin
			issueCnt <= issueCnt + 1'b1;
		end
	end

	// Only one pipeline may take a given command
	assert property (@(posedge clock) disable iff (reset)
		!(addCmd.valid && mulCmd.valid))
		else $error("issueDecode: add and multiply commands valid together");

endmodule

`default_nettype wire

// File: hdl/mulPipe.sv
`timescale 1ns/10ps
`default_nettype none

module mulPipe #(
	parameter int MUL_DEPTH = 4
) (
	input wire logic clock,
	input wire logic reset,
	input wire instrPkg::command_t cmd,
	input wire resultPkg::issueNo_t tag,
	output resultPkg::wbResult_t result
);
	import instrPkg::*;
	import resultPkg::*;

	data_t product;
	token_t token;

	assign product = cmd.src1 * cmd.src2;	// Low 32 bits only
	assign token = '{valid: cmd.valid, issueNo: tag, dst: cmd.dst};

	//////////////////////////////////////////////////////////////////////
	// Product and token shift registers
	//////////////////////////////////////////////////////////////////////

	generate
		if (MUL_DEPTH == 1) begin : gNoStage
			assign result = '{token: token, data: product};
		end else begin : gStages
			data_t dataStage [MUL_DEPTH-1];
			token_t tokStage [MUL_DEPTH-1];

			always_ff @(posedge clock) begin	// Payload only
				dataStage[0] <= product;
				for (int i = 1; i < MUL_DEPTH - 1; i++) begin
					dataStage[i] <= dataStage[i-1];
				end
			end

			always_ff @(posedge clock) begin
				tokStage[0] <= token;
				for (int i = 1; i < MUL_DEPTH - 1; i++) begin
					tokStage[i] <= tokStage[i-1];
				end
				if (reset) begin
					for (int i = 0; i < MUL_DEPTH - 1; i++) begin
						tokStage[i].valid <= 1'b0;
					end
				end
			end

			assign result = '{token: tokStage[MUL_DEPTH-2], data: dataStage[MUL_DEPTH-2]};
		end
	endgenerate

endmodule

`default_nettype wire

// File: hdl/resultPkg.sv
`default_nettype none

package resultPkg;

	//////////////////////////////////////////////////////////////////////
	// Result side, tokens and write-back
	//////////////////////////////////////////////////////////////////////

	typedef logic [3:0] issueNo_t;	// Also the commit slot index

	// Travels next to the data through a pipeline
	typedef struct packed {
		logic valid;
		issueNo_t issueNo;
		instrPkg::regIdx_t dst;
	} token_t;	// 10 bits

	typedef struct packed {
		token_t token;
		instrPkg::data_t data;
	} wbResult_t;	// 42 bits

endpackage

`default_nettype wire

// File: tests/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int HALF_PERIOD = 2,	// 4 ns period
	parameter int RESET_CYCLES = 2
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);	// Release away from the active edge
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: tests/execUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module execUnitTb;
	import instrPkg::*;
	import resultPkg::*;

	localparam int ADD_DEPTH = 2;
	localparam int MUL_DEPTH = 4;
	localparam int NUM_COMMANDS = 400;
	localparam int TIMEOUT_CYCLES = NUM_COMMANDS * 4 * (MUL_DEPTH + 2);

	logic clock;
	logic reset;
	command_t command;
	logic commitGrant;
	wbResult_t writeBack;
	logic full;

	int seed = 6747;
	int errorCount = 0;
	int acceptedCount = 0;
	int commitCount = 0;
	int cycleCount = 0;
	wbResult_t model [$];	// Expected write-backs in acceptance order
	logic heldBack = 1'b0;	// Last edge saw valid while full
	logic lastGrant = 1'b0;
	logic sawFull = 1'b0;

	clockGen i_clockGen (
		.clock	(clock),
		.reset	(reset)
	);

	execUnit #(
		.ADD_DEPTH	(ADD_DEPTH),
		.MUL_DEPTH	(MUL_DEPTH)
	) i_execUnit (
		.clock		(clock),
		.reset		(reset),
		.command	(command),
		.commitGrant	(commitGrant),
		.writeBack	(writeBack),
		.full		(full)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic wbResult_t expectedResult(input command_t cmd, input int issueIdx);
		wbResult_t exp;
		exp.token.valid = 1'b1;
		exp.token.issueNo = issueNo_t'(issueIdx);	// Slot number wraps at 16
		exp.token.dst = cmd.dst;
		case (cmd.op)
			opAdd: exp.data = cmd.src1 + cmd.src2;
			opSub: exp.data = cmd.src1 - cmd.src2;
			opMul: exp.data = cmd.src1 * cmd.src2;	// Low 32 bits
			default: exp.data = cmd.src1;	// Move
		endcase
		return exp;
	endfunction

	task automatic checkWriteBack(input resultPkg::wbResult_t actual);
		wbResult_t exp;
		if (model.size() == 0) begin
			errorCount++;
			$display("Error: write-back pulse with no command left in the model");
			return;
		end
		exp = model.pop_front();
		if (actual.data !== exp.data) begin
			errorCount++;
			$display("[FAIL] writeBack.data: expected %h, got %h", exp.data, actual.data);
		end
		if (actual.token.dst !== exp.token.dst) begin
			errorCount++;
			$display("[FAIL] writeBack.token.dst: expected %h, got %h",
				exp.token.dst, actual.token.dst);
		end
		if (actual.token.issueNo !== exp.token.issueNo) begin
			errorCount++;
			$display("[FAIL] writeBack.token.issueNo: expected %h, got %h",
				exp.token.issueNo, actual.token.issueNo);
		end
	endtask

	task automatic checkFull(input logic expected);
		if (full !== expected) begin
			errorCount++;
			$display("[FAIL] full: expected %h, got %h", expected, full);
		end
	endtask

	task automatic printSummary();
		$display("Summary: %0d errors, %0d accepted, %0d committed",
			errorCount, acceptedCount, commitCount);
	endtask

	// Sampled before the DUT registers update
	always @(posedge clock) begin
		if (!reset) begin
			if (writeBack.token.valid) begin
				if (!lastGrant) begin
					errorCount++;
					$display("Error: write-back pulse after a cycle without commit grant");
				end
				checkWriteBack(writeBack);
				commitCount++;
			end
			checkFull((acceptedCount - commitCount) == 16);
			if (full) begin
				sawFull = 1'b1;
			end
			if (command.valid && !full) begin
				model.push_back(expectedResult(command, acceptedCount));
				acceptedCount++;
			end
			heldBack = command.valid && full;
		end
		lastGrant = commitGrant;
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			printSummary();
			$display("Simulation FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus, driven on the falling edge
	//////////////////////////////////////////////////////////////////////

	function automatic logic rollPercent(input int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	task automatic driveCommand(input logic valid);
		command_t c;
		c.valid = valid;
		c.op = opCode_t'(2'($random(seed)));
		c.dst = regIdx_t'($random(seed));
		c.src1 = $random(seed);
		c.src2 = $random(seed);
		command = c;
	endtask

	task automatic stepCycle(input int validPct, input int grantPct);
		@(negedge clock);
		commitGrant = rollPercent(grantPct);
		if (!heldBack) begin	// A refused command stays on the bus
			driveCommand(rollPercent(validPct));
		end
	endtask

	task automatic driveOp(input opCode_t op, input regIdx_t dst, input data_t a, input data_t b);
		@(negedge clock);
		while (heldBack) begin
			@(negedge clock);
		end
		commitGrant = 1'b1;
		command = '{valid: 1'b1, op: op, dst: dst, src1: a, src2: b};
	endtask

	initial begin
		command = '0;
		commitGrant = 1'b0;
		@(posedge clock);
		wait (reset == 1'b0);
		@(negedge clock);
		if (writeBack.token.valid !== 1'b0) begin
			errorCount++;
			$display("[FAIL] writeBack.token.valid: expected %h, got %h",
				1'b0, writeBack.token.valid);
		end
		checkFull(1'b0);

		// Multiply followed by quicker adder ops
		driveOp(opMul, 5'd1, 32'h1234_5678, 32'h0000_1001);
		driveOp(opAdd, 5'd2, 32'h0000_0010, 32'h0000_0020);
		driveOp(opSub, 5'd3, 32'h0000_0005, 32'h0000_0009);
		driveOp(opMov, 5'd4, 32'hDEAD_BEEF, 32'h0BAD_F00D);
		while (model.size() != 0) begin
			stepCycle(0, 100);
		end

		// Back-pressure with grant held low
		sawFull = 1'b0;
		repeat (40) stepCycle(100, 0);
		if (!sawFull) begin
			errorCount++;
			$display("Error: full never rose while commit grant was held low");
		end

		while (acceptedCount < NUM_COMMANDS) begin
			stepCycle(80, 70);
		end

		while (model.size() != 0) begin	// Drain with grant high
			stepCycle(0, 100);
		end
		repeat (2 * MUL_DEPTH) stepCycle(0, 100);
		if (commitCount != acceptedCount) begin
			errorCount++;
			$display("Error: %0d commands accepted but %0d committed",
				acceptedCount, commitCount);
		end

		printSummary();
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
